//--- compile.f
source/scannerPkg.sv
source/scanEngine.sv
source/frameFifo.sv
source/serialLinkTx.sv
source/scannerTop.sv
verification/scannerLink_props.sv
verification/scannerTb.sv

//--- Bender.yml
package:
  name: scanner_node

sources:
  - source/scannerPkg.sv
  - source/scanEngine.sv
  - source/frameFifo.sv
  - source/serialLinkTx.sv
  - source/scannerTop.sv
  - target: simulation
    files:
      - verification/scannerLink_props.sv
      - verification/scannerTb.sv

//--- verification/scannerTb.sv
module scannerTb;
	import scannerPkg::*;

	logic clk;
	logic rst;
	peerCode_e peerCommand;
	logic readyForTransfer;
	logic clkOut;
	logic dataOut;

	int decoded [$]; // Frames seen on the link, oldest first
	int expected [$];
	logic [15:0] frameWord; // Bits of the frame in progress
	int bitCount;
	int lowCount; // Cycles since the last strobe
	int seed;
	int cycleCount;
	int timeoutCycles;
	int testCount;
	int checkCount;
	int errorCount;
	int testErrors;

	scannerTop u_scannerTop (
		.clk(clk),
		.rst(rst),
		.peerCommand(peerCommand),
		.readyForTransfer(readyForTransfer),
		.clkOut(clkOut),
		.dataOut(dataOut)
	);

	always #10 clk = ~clk;

	// Strobe lasts a whole cycle, so the falling edge sees settled data
	always @(negedge clk) begin
		if (rst) begin
			bitCount = 0;
			lowCount = 0;
			frameWord = '0;
		end else if (clkOut) begin
			frameWord = {frameWord[14:0], dataOut}; // MSB arrives first
			bitCount++;
			lowCount = 0;
		end else begin
			lowCount++;
			if (lowCount == 2 && bitCount != 0) begin // Idle gap closes the frame
				decoded.push_back(int'(frameWord));
				bitCount = 0;
				frameWord = '0;
			end
		end
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > timeoutCycles) begin
			$display("Timeout: the expected frames did not arrive within %0d cycles",
				timeoutCycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic int dataValue(int fill);
		return (int'(cmdData) << 8) | fill; // Prefix byte, then reserved nibble and level
	endfunction

	function automatic int randomGap();
		return $unsigned($random(seed)) % 16;
	endfunction

	task automatic checkValue(string name, int actual, int wanted);
		checkCount++;
		assert (actual == wanted) else begin
			$display("[FAIL] %0t %s expected %0h got %0h", $time, name, wanted, actual);
			testErrors++;
		end
	endtask

	task automatic compareFrames();
		int n;
		checkValue("frameCount", decoded.size(), expected.size());
		n = (decoded.size() < expected.size()) ? decoded.size() : expected.size();
		for (int i = 0; i < n; i++)
			checkValue($sformatf("dataOut frame %0d", i), decoded[i], expected[i]);
	endtask

	task automatic waitFrames(int count);
		do
			@(posedge clk);
		while (decoded.size() < count);
		@(negedge clk); // Back to the drive edge
	endtask

	task automatic idleCycles(int count);
		repeat (count) @(negedge clk);
	endtask

	task automatic sendPeer(peerCode_e code);
		peerCommand = code;
		@(negedge clk);
		peerCommand = peerNone;
	endtask

	// Status frames at levels 7, 8 and 9, then the level if it is handed on
	task automatic expectScan(logic withData);
		expected.push_back(cmdReady);
		expected.push_back(cmdStart);
		expected.push_back(cmdFull);
		if (withData)
			expected.push_back(dataValue(levelFull));
	endtask

	task automatic startTest();
		testCount++;
		testErrors = 0;
		decoded.delete();
		expected.delete();
	endtask

	task automatic finishTest(string name);
		$display("test %0d %s: %s", testCount, name, (testErrors == 0) ? "ok" : "mismatch");
		errorCount += testErrors;
	endtask

	initial begin
		int mode;
		clk = 1'b0;
		rst = 1'b1;
		peerCommand = peerNone;
		readyForTransfer = 1'b0;
		seed = 32'h62340351;
		cycleCount = 0;
		timeoutCycles = 200 * (7 + 2); // Seven scans of 200 cycles plus two more for quiet waits
		testCount = 0;
		checkCount = 0;
		errorCount = 0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		// Long enough for a scan started without a command to reach the link
		startTest();
		repeat (100) begin
			@(negedge clk);
			checkValue("clkOut", clkOut, 0);
			checkValue("dataOut", dataOut, 0);
		end
		compareFrames();
		finishTest("idle after reset");

		startTest();
		readyForTransfer = 1'b1;
		sendPeer(peerStart);
		expectScan(1'b1);
		waitFrames(4);
		compareFrames();
		readyForTransfer = 1'b0;
		finishTest("scan with transfer");

		startTest();
		sendPeer(peerStart);
		expectScan(1'b0);
		waitFrames(3);
		idleCycles(60);
		compareFrames(); // Standby sends nothing
		readyForTransfer = 1'b1;
		expected.push_back(dataValue(levelFull));
		waitFrames(4);
		compareFrames();
		readyForTransfer = 1'b0;
		finishTest("standby then transfer");

		startTest();
		sendPeer(peerStart);
		expectScan(1'b0);
		waitFrames(3);
		sendPeer(peerHalf);
		readyForTransfer = 1'b1; // Ignored once the engine is back in IDLE
		idleCycles(60);
		compareFrames();
		sendPeer(peerStart);
		expectScan(1'b1);
		waitFrames(7);
		compareFrames();
		readyForTransfer = 1'b0;
		finishTest("standby dropped by peerHalf");

		startTest();
		for (int scan = 0; scan < 3; scan++) begin
			mode = $unsigned($random(seed)) % 3; // 0 ready early, 1 ready late, 2 dropped
			idleCycles(randomGap());
			readyForTransfer = (mode == 0);
			sendPeer(peerStart);
			expectScan(mode != 2);
			waitFrames((mode == 1) ? expected.size() - 1 : expected.size());
			idleCycles(randomGap());
			if (mode == 1) begin
				readyForTransfer = 1'b1;
				waitFrames(expected.size());
			end else if (mode == 2) begin
				sendPeer(peerHalf);
			end
			readyForTransfer = 1'b0;
		end
		idleCycles(60);
		compareFrames();
		finishTest("random back to back scans");

		if (u_scannerTop.u_linkProps.violations != 0)
			$display("Link assertions failed %0d times", u_scannerTop.u_linkProps.violations);
		errorCount += u_scannerTop.u_linkProps.violations;
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- verification/scannerLink_props.sv
module scannerLink_props (
	input logic clk,
	input logic rst,
	input logic pushReq,
	input logic pushAck,
	input logic popReq,
	input logic popAck,
	input logic clkOut,
	input scannerPkg::linkFrame_t popFrame
);
	int violations = 0; // Failed assertion count
	int bitsOwed; // Strobes still due for the last popped frame
	logic popAckLast;

	// Each popped frame allows 8 strobes, or 16 with the data prefix
	always @(posedge clk) begin
		if (rst) begin
			bitsOwed <= 0;
			popAckLast <= 1'b0;
		end else begin
			popAckLast <= popAck;
			if (popAck && !popAckLast)
				bitsOwed <= popFrame.isData ? 16 : 8;
			else if (clkOut && bitsOwed > 0)
				bitsOwed <= bitsOwed - 1;
		end
	end

	// A request stays up until the slave answers
	assert property (@(posedge clk) disable iff (rst) pushReq && !pushAck |=> pushReq)
		else begin
			$error("pushReq dropped before pushAck arrived");
			violations++;
		end

	assert property (@(posedge clk) disable iff (rst) $rose(pushAck) |-> pushReq)
		else begin
			$error("pushAck rose without a pending pushReq");
			violations++;
		end

	assert property (@(posedge clk) disable iff (rst) popReq && !popAck |=> popReq)
		else begin
			$error("popReq dropped before popAck arrived");
			violations++;
		end

	assert property (@(posedge clk) disable iff (rst) $rose(popAck) |-> popReq)
		else begin
			$error("popAck rose without a pending popReq");
			violations++;
		end

	// No strobes owed means the link is idle
	assert property (@(posedge clk) disable iff (rst) bitsOwed == 0 |-> !clkOut)
		else begin
			$error("clkOut strobed while the transmitter was idle");
			violations++;
		end

endmodule

bind scannerTop scannerLink_props u_linkProps (
	.clk(clk),
	.rst(rst),
	.pushReq(pushReq),
	.pushAck(pushAck),
	.popReq(popReq),
	.popAck(popAck),
	.clkOut(clkOut),
	.popFrame(popFrame)
);

//--- source/scannerTop.sv
module scannerTop (
	input logic clk,
	input logic rst,
	input scannerPkg::peerCode_e peerCommand,
	input logic readyForTransfer,
	output logic clkOut,
	output logic dataOut
);
	import scannerPkg::*;

	logic pushReq;
	logic pushAck;
	linkFrame_t pushFrame; // Engine to FIFO
	logic popReq;
	logic popAck;
	linkFrame_t popFrame; // FIFO to transmitter

	scanEngine u_scanEngine (
		.clk(clk),
		.rst(rst),
		.peerCommand(peerCommand),
		.readyForTransfer(readyForTransfer),
		.pushAck(pushAck),
		.pushReq(pushReq),
		.pushFrame(pushFrame)
	);

	frameFifo u_frameFifo (
		.clk(clk),
		.rst(rst),
		.pushReq(pushReq),
		.pushFrame(pushFrame),
		.popAck(popAck),
		.pushAck(pushAck),
		.popReq(popReq),
		.popFrame(popFrame)
	);

	serialLinkTx u_serialLinkTx (
		.clk(clk),
		.rst(rst),
		.popReq(popReq),
		.popFrame(popFrame),
		.popAck(popAck),
		.clkOut(clkOut),
		.dataOut(dataOut)
	);

endmodule

//--- source/serialLinkTx.sv
module serialLinkTx (
	input logic clk,
	input logic rst,
	input logic popReq,
	input scannerPkg::linkFrame_t popFrame,
	output logic popAck,
	output logic clkOut,
	output logic dataOut
);
	import scannerPkg::*;

	typedef enum logic [1:0] {
		txIdle,
		txSend,
		txGap
	} txState_e;

	txState_e state;
	logic [15:0] shiftReg; // MSB goes out first
	logic [15:0] loadWord;
	logic [4:0] bitsLeft;
	logic [$clog2(bitCycles)-1:0] phase;
	logic phaseEnd;
	logic startFrame;

	assign phaseEnd = (phase == bitCycles - 1);
	assign startFrame = (state == txIdle) && popReq && !popAck;

	// Strobe in the last cycle of each bit
	assign clkOut = (state == txSend) && phaseEnd;
	assign dataOut = (state == txSend) && shiftReg[15];

	always_comb begin
		if (popFrame.isData)
			loadWord = {cmdData, popFrame.payload.dataWord}; // Prefix, then level
		else
			loadWord = {popFrame.payload.commandCode, 8'h00}; // Low byte unused
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= txIdle;
			popAck <= 1'b0;
			phase <= '0;
			bitsLeft <= 5'd0;
		end else begin
			if (popAck && !popReq)
				popAck <= 1'b0; // FIFO has removed the entry
			case (state)
				txIdle: begin
					if (startFrame) begin
						state <= txSend;
						popAck <= 1'b1; // Frame latched this edge
						phase <= '0;
						bitsLeft <= popFrame.isData ? 5'd16 : 5'd8;
					end
				end
				txSend: begin
					phase <= phaseEnd ? '0 : phase + 1'b1;
					if (phaseEnd) begin
						bitsLeft <= bitsLeft - 1'b1;
						if (bitsLeft == 5'd1)
							state <= txGap;
					end
				end
				txGap: begin
					// One idle bit period marks the frame end
					phase <= phaseEnd ? '0 : phase + 1'b1;
					if (phaseEnd)
						state <= txIdle;
				end
				default: state <= txIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (startFrame)
			shiftReg <= loadWord;
		else if (state == txSend && phaseEnd)
			shiftReg <= {shiftReg[14:0], 1'b0}; // Next bit after strobe
	end

endmodule

//--- source/frameFifo.sv
module frameFifo (
	input logic clk,
	input logic rst,
	input logic pushReq,
	input scannerPkg::linkFrame_t pushFrame,
	input logic popAck,
	output logic pushAck,
	output logic popReq,
	output scannerPkg::linkFrame_t popFrame
);
	import scannerPkg::*;

	linkFrame_t entries [fifoDepth];
	logic [$clog2(fifoDepth)-1:0] wrPtr, rdPtr; // Wrap naturally, depth is a power of two
	logic [$clog2(fifoDepth):0] count;
	logic doPush;
	logic doPop;

	// Store once per request, only with a free entry
	assign doPush = pushReq && !pushAck && (count < fifoDepth);
	assign doPop = popReq && popAck;
	assign popFrame = entries[rdPtr]; // Head entry

	always_ff @(posedge clk) begin
		if (doPush)
			entries[wrPtr] <= pushFrame;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			pushAck <= 1'b0;
			popReq <= 1'b0;
		end else begin
			// Write side slave
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
				pushAck <= 1'b1;
			end else if (!pushReq) begin
				pushAck <= 1'b0; // Phase 4
			end

			// Read side master
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
				popReq <= 1'b0;
			end else if (!popAck && count != 0) begin
				popReq <= 1'b1; // Next entry once ack is low
			end

			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- source/scanEngine.sv
module scanEngine (
	input logic clk,
	input logic rst,
	input scannerPkg::peerCode_e peerCommand,
	input logic readyForTransfer,
	input logic pushAck,
	output logic pushReq,
	output scannerPkg::linkFrame_t pushFrame
);
	import scannerPkg::*;

	typedef enum logic [1:0] {
		stateIdle,
		stateActive,
		stateStandby,
		stateTransfer
	} engineState_e;

	engineState_e state, stateNext;
	logic [3:0] level, levelNext; // Fake sample buffer fill
	logic [$clog2(tickDivide)-1:0] tickCount;
	logic tick;
	logic pushBusy; // High from request until ack has dropped again
	logic pushDone;
	logic startPush;
	linkFrame_t frameNext;

	function automatic linkFrame_t commandFrame(cmdCode_e code);
		linkFrame_t frame;
		frame.isData = 1'b0;
		frame.payload.commandCode = code;
		return frame;
	endfunction

	function automatic linkFrame_t dataFrame(logic [3:0] fill);
		linkFrame_t frame;
		frame.isData = 1'b1;
		frame.payload.dataWord.reserved = 4'h0;
		frame.payload.dataWord.fillLevel = fill;
		return frame;
	endfunction

	assign tick = (tickCount == tickDivide - 1); // Slow fill rate
	assign pushDone = pushBusy && !pushReq && !pushAck; // Four phases complete

	always_comb begin
		stateNext = state;
		levelNext = level;
		startPush = 1'b0;
		frameNext = '0;
		case (state)
			stateIdle: begin
				if (peerCommand == peerStart) begin
					stateNext = stateActive;
					levelNext = 4'h0; // Fresh scan
				end
			end
			stateActive: begin
				if (pushDone && level == levelFull) begin // cmdFull acknowledged
					if (readyForTransfer) begin
						stateNext = stateTransfer;
						startPush = 1'b1;
						frameNext = dataFrame(level);
					end else begin
						stateNext = stateStandby;
					end
				end else if (tick && !pushBusy && level < levelFull) begin
					// Counting stalls while a frame is outstanding
					levelNext = level + 1'b1;
					if (levelNext == levelReady) begin
						startPush = 1'b1;
						frameNext = commandFrame(cmdReady);
					end else if (levelNext == levelStart) begin
						startPush = 1'b1;
						frameNext = commandFrame(cmdStart);
					end else if (levelNext == levelFull) begin
						startPush = 1'b1;
						frameNext = commandFrame(cmdFull);
					end
				end
			end
			stateStandby: begin
				if (readyForTransfer) begin
					stateNext = stateTransfer;
					startPush = 1'b1;
					frameNext = dataFrame(level);
				end else if (peerCommand == peerHalf) begin
					stateNext = stateIdle; // Data dropped, nothing sent
					levelNext = 4'h0;
				end
			end
			stateTransfer: begin
				if (pushDone) begin
					stateNext = stateIdle;
					levelNext = 4'h0; // Level handed downstream
				end
			end
			default: stateNext = stateIdle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stateIdle;
			level <= 4'h0;
			tickCount <= '0;
			pushReq <= 1'b0;
			pushBusy <= 1'b0;
		end else begin
			state <= stateNext;
			level <= levelNext;
			tickCount <= tick ? '0 : tickCount + 1'b1;
			if (startPush) begin
				pushReq <= 1'b1;
				pushBusy <= 1'b1;
			end else begin
				if (pushReq && pushAck)
					pushReq <= 1'b0; // Phase 3
				if (pushDone)
					pushBusy <= 1'b0;
			end
		end
	end

	// Frame held stable while pushReq is up
	always_ff @(posedge clk) begin
		if (startPush)
			pushFrame <= frameNext;
	end

endmodule

//--- source/scannerPkg.sv
package scannerPkg;

	// Status and data commands sent on the serial link
	typedef enum logic [7:0] {
		cmdReady = 8'd2, // READY_TO_TRANSFER
		cmdStart = 8'd3, // START_SCANNING
		cmdFull = 8'd4, // BUFFER_FULL
		cmdData = 8'd7 // Prefix ahead of a data word
	} cmdCode_e;

	// Commands from the peer node
	typedef enum logic [1:0] {
		peerNone = 2'd0,
		peerStart = 2'd1, // Begin a scan
		peerHalf = 2'd2 // Other buffer is at 50%
	} peerCode_e;

	typedef struct packed {
		logic [3:0] reserved; // Always zero
		logic [3:0] fillLevel;
	} dataWord_t;

	// One payload byte, read as a command or as a data word
	typedef union packed {
		cmdCode_e commandCode;
		dataWord_t dataWord;
	} framePayload_u;

	typedef struct packed {
		logic isData; // Selects the dataWord view of payload
		framePayload_u payload;
	} linkFrame_t;

	localparam int levelFull = 9; // Buffer full
	localparam int levelReady = 7; // Triggers cmdReady
	localparam int levelStart = 8; // Triggers cmdStart

	localparam int tickDivide = 8; // clk cycles per fill tick
	localparam int fifoDepth = 4; // Frame queue entries
	localparam int bitCycles = 2; // clk cycles per serial bit

endpackage
